// File: bch_chien.sv
`timescale 1ns/1ps

// Search over the data positions.
// Two power registers hold alpha^i and alpha^(3i) for the current position i.
// Adding them to the syndromes gives the syndromes of the word with bit i flipped.
module bch_chien (
	input logic clk,
	input logic arst_n,
	input logic start,
	input bch_pkg::gf_t s1,
	input bch_pkg::gf_t s3,
	bch_chien_if.source ch
);

	logic active;
	bch_pkg::pos_t pos;
	bch_pkg::gf_t s1_q;
	bch_pkg::gf_t s3_q;
	bch_pkg::gf_t p1;
	bch_pkg::gf_t p3;

	// The position counter runs from 10 to 30 and frames the output.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			active <= 1'b0;
			pos <= '0;
		end else begin
			if (start) begin
				active <= 1'b1;
				pos <= bch_pkg::first_data_pos;
			end else if (active) begin
				pos <= pos + 1'b1;
				if (pos == bch_pkg::last_data_pos) begin
					active <= 1'b0;
				end
			end
		end
	end

	// The syndromes are held for the whole search.
	// The power registers step by alpha and alpha^3 per position.
	always_ff @(posedge clk) begin
		if (start) begin
			s1_q <= s1;
			s3_q <= s3;
			p1 <= bch_pkg::alpha_first;
			p3 <= bch_pkg::alpha3_first;
		end else if (active) begin
			p1 <= bch_pkg::gf_mul(p1, bch_pkg::alpha);
			p3 <= bch_pkg::gf_mul(p3, bch_pkg::alpha3);
		end
	end

	assign ch.valid = active;
	assign ch.first = active && (pos == bch_pkg::first_data_pos);
	assign ch.last = active && (pos == bch_pkg::last_data_pos);

	// Flipping bit i adds alpha^i to S1 and alpha^(3i) to S3.
	assign ch.ch1 = s1_q ^ p1;
	assign ch.ch3 = s3_q ^ p3;

endmodule

// File: bch_chien_if.sv
`timescale 1ns/1ps

// Per-position output of the search.
// For position i, ch1 is S1 xor alpha^i and ch3 is S3 xor alpha^(3i).
// These are the syndromes the word would have with bit i flipped.
interface bch_chien_if;

	// High for one cycle per data position.
	logic valid;

	// Marks position 10, the first data position.
	logic first;

	// Marks position 30, the last data position.
	logic last;

	// Flipped syndromes.
	bch_pkg::gf_t ch1;
	bch_pkg::gf_t ch3;

	modport source (output valid, output first, output last, output ch1, output ch3);

	modport sink (input valid, input first, input last, input ch1, input ch3);

endinterface

// File: bch_correct.sv
`timescale 1ns/1ps

// Correction and output stage.
// It takes a word from the syndrome stage, starts the search, collects the
// error decisions into a mask and offers the corrected data to the sink.
module bch_correct (
	input logic clk,
	input logic arst_n,
	bch_synd_if.sink synd,
	output logic start,
	output bch_pkg::gf_t s1,
	output bch_pkg::gf_t s3,
	bch_err_if.sink ei,
	output logic out_req,
	input logic out_ack,
	output bch_pkg::data_t out_data,
	output bch_pkg::err_count_t out_err_count
);

	typedef enum logic [1:0] {st_idle, st_search, st_offer, st_release} state_t;

	state_t state;
	logic ack_q;
	logic start_q;
	logic out_req_q;
	logic accept;
	logic shift;
	bch_pkg::word_t word_q;
	bch_pkg::gf_t s1_q;
	bch_pkg::gf_t s3_q;
	bch_pkg::data_t mask;
	bch_pkg::data_t new_mask;
	bch_pkg::data_t data_bits;
	bch_pkg::data_t out_data_q;
	bch_pkg::err_count_t out_err_q;

	// A new word is taken only when free and after the last ack has fallen.
	assign accept = (state == st_idle) && synd.req && !ack_q;
	assign shift = (state == st_search) && ei.valid;

	// Decisions arrive from position 10 up, so each enters at the top of the mask.
	assign new_mask = {ei.err, mask[bch_pkg::k-1:1]};
	assign data_bits = word_q[bch_pkg::n-1:bch_pkg::first_data_pos];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			ack_q <= 1'b0;
			start_q <= 1'b0;
			out_req_q <= 1'b0;
		end else begin
			start_q <= accept;
			if (accept) begin
				ack_q <= 1'b1;
			end else if (ack_q && !synd.req) begin
				ack_q <= 1'b0;
			end
			case (state)
				st_idle: begin
					if (accept) begin
						state <= st_search;
					end
				end
				st_search: begin
					if (ei.valid && ei.last) begin
						state <= st_offer;
						out_req_q <= 1'b1;
					end
				end
				st_offer: begin
					if (out_ack) begin
						out_req_q <= 1'b0;
						state <= st_release;
					end
				end
				st_release: begin
					// The stage is free again once the sink has dropped its ack.
					if (!out_ack) begin
						state <= st_idle;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			word_q <= synd.word;
			s1_q <= synd.s1;
			s3_q <= synd.s3;
		end
		if (shift) begin
			mask <= new_mask;
		end
		// An uncorrectable word is passed through as received.
		if (shift && ei.last) begin
			if (ei.err_count == 2'd3) begin
				out_data_q <= data_bits;
			end else begin
				out_data_q <= data_bits ^ new_mask;
			end
			out_err_q <= ei.err_count;
		end
	end

	assign synd.ack = ack_q;
	assign start = start_q;
	assign s1 = s1_q;
	assign s3 = s3_q;
	assign out_req = out_req_q;
	assign out_data = out_data_q;
	assign out_err_count = out_err_q;

endmodule

// File: bch_decoder.sv
`timescale 1ns/1ps

// BCH (31,21) decoder correcting up to two errors.
// The syndrome stage can hold one word while the correction stage works on
// the previous one.
module bch_decoder (
	input logic clk,
	input logic arst_n,
	input logic in_req,
	input bch_pkg::word_t in_word,
	output logic in_ack,
	output logic out_req,
	input logic out_ack,
	output bch_pkg::data_t out_data,
	output bch_pkg::err_count_t out_err_count
);

	bch_synd_if synd_bus ();
	bch_err_if err_bus ();

	// Search start and the syndromes of the word under correction.
	logic start;
	bch_pkg::gf_t s1;
	bch_pkg::gf_t s3;

	bch_syndrome syndrome_i (
		.clk(clk),
		.arst_n(arst_n),
		.in_req(in_req),
		.in_word(in_word),
		.in_ack(in_ack),
		.synd(synd_bus.source)
	);

	bch_error_dec error_dec_i (
		.clk(clk),
		.arst_n(arst_n),
		.start(start),
		.s1(s1),
		.s3(s3),
		.eo(err_bus.source)
	);

	bch_correct correct_i (
		.clk(clk),
		.arst_n(arst_n),
		.synd(synd_bus.sink),
		.start(start),
		.s1(s1),
		.s3(s3),
		.ei(err_bus.sink),
		.out_req(out_req),
		.out_ack(out_ack),
		.out_data(out_data),
		.out_err_count(out_err_count)
	);

endmodule

// File: bch_decoder_tb.sv
`timescale 1ns/1ps

// Testbench for the BCH (31,21) decoder.
// Words are encoded by polynomial division, hit with 0 to 3 bit errors and
// sent through the input handshake. A queue holds what each word must decode to.
module bch_decoder_tb;

	localparam int words = 160;
	localparam int clk_period = 4;
	localparam int watchdog_cycles = words * 200 + 1000;
	localparam int parity_bits = bch_pkg::n - bch_pkg::k;

	// Generator x^10+x^9+x^8+x^6+x^5+x^3+1, the product of the minimal
	// polynomials of alpha and alpha^3.
	localparam logic [10:0] gen_poly = 11'h769;

	typedef struct packed {
		bch_pkg::data_t data;
		bch_pkg::err_count_t cnt;
	} expect_t;

	logic clk;
	logic arst_n;
	logic in_req;
	logic in_ack;
	logic out_req;
	logic out_ack;
	bch_pkg::word_t in_word;
	bch_pkg::data_t out_data;
	bch_pkg::err_count_t out_err_count;

	int errors;
	int checks;
	int sent;
	int received;
	expect_t exp_q[$];

	// Previous sampled values for the handshake monitor.
	logic in_req_q;
	logic in_ack_q;
	logic out_req_q;
	logic out_ack_q;
	bch_pkg::data_t out_data_q;

	tb_clock_gen clk_gen_i (.clk(clk));

	bch_decoder dut_i (
		.clk(clk),
		.arst_n(arst_n),
		.in_req(in_req),
		.in_word(in_word),
		.in_ack(in_ack),
		.out_req(out_req),
		.out_ack(out_ack),
		.out_data(out_data),
		.out_err_count(out_err_count)
	);

	// Compares one value against its expected value and counts a mismatch.
	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR at %0t: %s got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	// Power of alpha by repeated multiplication.
	function automatic bch_pkg::gf_t alpha_pow(input int e);
		bch_pkg::gf_t p;
		p = 5'd1;
		for (int i = 0; i < e % bch_pkg::n; i++) begin
			p = bch_pkg::gf_mul(p, bch_pkg::alpha);
		end
		return p;
	endfunction

	// Exponent l with alpha^l equal to v, for a nonzero v.
	function automatic int alpha_log(input bch_pkg::gf_t v);
		int l;
		l = 0;
		for (int i = 0; i < bch_pkg::n; i++) begin
			if (alpha_pow(i) == v) begin
				l = i;
			end
		end
		return l;
	endfunction

	// S1 in the upper half and S3 in the lower half, summed over the set bits.
	function automatic logic [9:0] syndromes(input bch_pkg::word_t w);
		bch_pkg::gf_t s1;
		bch_pkg::gf_t s3;
		s1 = '0;
		s3 = '0;
		for (int i = 0; i < bch_pkg::n; i++) begin
			if (w[i]) begin
				s1 = s1 ^ alpha_pow(i);
				s3 = s3 ^ alpha_pow(3 * i);
			end
		end
		return {s1, s3};
	endfunction

	// Systematic encoding. The parity is the remainder of d * x^10 by the generator.
	function automatic bch_pkg::word_t encode(input bch_pkg::data_t d);
		bch_pkg::word_t r;
		r = {d, {parity_bits{1'b0}}};
		for (int i = bch_pkg::n - 1; i >= parity_bits; i--) begin
			if (r[i]) begin
				r = r ^ (bch_pkg::word_t'(gen_poly) << (i - parity_bits));
			end
		end
		return {d, r[parity_bits-1:0]};
	endfunction

	// Mostly short delays, now and then a long stall to back up the pipeline.
	function automatic int pick_delay();
		if ($urandom_range(0, 3) == 0) begin
			return $urandom_range(10, 40);
		end
		return $urandom_range(0, 3);
	endfunction

	// One word through the input handshake.
	task automatic send_word(input bch_pkg::word_t w);
		@(posedge clk);
		in_req <= 1'b1;
		in_word <= w;
		@(posedge clk);
		while (!in_ack) @(posedge clk);
		in_req <= 1'b0;
		@(posedge clk);
		while (in_ack) @(posedge clk);
	endtask

	// Builds the words. The kind cycles through 0 to 3 flipped bits.
	task automatic run_driver();
		bch_pkg::data_t d;
		bch_pkg::word_t cw;
		bch_pkg::word_t rx;
		logic [9:0] syn;
		int kind;
		int p1;
		int p2;
		int p3;
		expect_t e;
		for (int w = 0; w < words; w++) begin
			kind = w % 4;
			d = bch_pkg::data_t'($urandom());
			cw = encode(d);
			check(syndromes(cw), 0, $sformatf("word %0d encoder syndromes", w));
			p1 = $urandom_range(0, bch_pkg::n - 1);
			p2 = $urandom_range(0, bch_pkg::n - 1);
			while (p2 == p1) p2 = $urandom_range(0, bch_pkg::n - 1);
			// The third bit cancels S1, which leaves S3 nonzero for any triple.
			p3 = alpha_log(alpha_pow(p1) ^ alpha_pow(p2));
			rx = cw;
			if (kind >= 1) rx = rx ^ (bch_pkg::word_t'(1) << p1);
			if (kind >= 2) rx = rx ^ (bch_pkg::word_t'(1) << p2);
			if (kind == 3) rx = rx ^ (bch_pkg::word_t'(1) << p3);
			syn = syndromes(rx);
			e.data = d;
			e.cnt = bch_pkg::err_count_t'(kind);
			if (kind == 3) begin
				// Only triples the decoder can flag are sent.
				if (syn[9:5] != '0 || syn[4:0] == '0) continue;
				e.data = rx[bch_pkg::n-1:parity_bits];
			end
			exp_q.push_back(e);
			sent++;
			send_word(rx);
		end
	endtask

	// Output side. Each offered word is compared with the head of the queue.
	task automatic run_sink();
		expect_t e;
		bch_pkg::data_t got_data;
		bch_pkg::err_count_t got_cnt;
		forever begin
			@(posedge clk);
			if (out_req) begin
				got_data = out_data;
				got_cnt = out_err_count;
				if (exp_q.size() == 0) begin
					errors++;
					$display("The decoder offered a word at %0t with none outstanding", $time);
				end else begin
					e = exp_q.pop_front();
					check(got_data, e.data, $sformatf("word %0d data", received));
					check(got_cnt, e.cnt, $sformatf("word %0d error count", received));
				end
				received++;
				repeat (pick_delay()) @(posedge clk);
				out_ack <= 1'b1;
				@(posedge clk);
				while (out_req) @(posedge clk);
				repeat (pick_delay()) @(posedge clk);
				out_ack <= 1'b0;
			end
		end
	endtask

	// Four-phase order on both sides, and stable output data while offered.
	always @(posedge clk) begin
		if (arst_n) begin
			if (in_ack && !in_ack_q) check(in_req, 1'b1, "in_ack rose without in_req");
			if (!in_ack && in_ack_q) check(in_req, 1'b0, "in_ack fell while in_req high");
			if (in_req && !in_req_q) check(in_ack, 1'b0, "in_req rose before in_ack fell");
			if (out_req && !out_req_q) check(out_ack, 1'b0, "out_req rose before out_ack fell");
			if (!out_req && out_req_q) check(out_ack, 1'b1, "out_req fell without out_ack");
			if (out_ack && !out_ack_q) check(out_req, 1'b1, "out_ack rose without out_req");
			if (out_req && out_req_q) check(out_data, out_data_q, "out_data changed while offered");
		end
		in_req_q = in_req;
		in_ack_q = in_ack;
		out_req_q = out_req;
		out_ack_q = out_ack;
		out_data_q = out_data;
	end

	initial begin
		void'($urandom(32'h6beefb52));
		errors = 0;
		checks = 0;
		sent = 0;
		received = 0;
		arst_n = 1'b0;
		in_req = 1'b0;
		in_word = '0;
		out_ack = 1'b0;
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
		// The sink thread draws its random stream from the seeded main thread.
		fork
			run_sink();
		join_none
		run_driver();
		while (received < sent) @(posedge clk);
		// A few more cycles catch any extra word.
		repeat (50) @(posedge clk);
		$display("Summary: %0d sent, %0d received, %0d checks, %0d errors",
			sent, received, checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// Budget of 200 cycles per word plus a margin.
	initial begin
		#(watchdog_cycles * clk_period);
		$display("Timeout: the decoder did not finish all words in %0d cycles", watchdog_cycles);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: bch_err_if.sv
`timescale 1ns/1ps

// Error decisions from the error decision block to the correction stage.
// One decision is given per data position, in order from position 10 up.
interface bch_err_if;

	// High for one cycle per data position.
	logic valid;

	// Marks the decision for the last data position.
	logic last;

	// High when the bit at the current position is in error.
	logic err;

	// Error class of the whole word, stable for the whole search.
	bch_pkg::err_count_t err_count;

	modport source (output valid, output last, output err, output err_count);

	modport sink (input valid, input last, input err, input err_count);

endinterface

// File: bch_error_dec.sv
`timescale 1ns/1ps

// Error decision for the double error correcting code.
// The class of the received word is kept, and each data position is tested by
// classifying the syndromes of the word with that bit flipped.
// A bit is in error when the flip lowers the class.
module bch_error_dec (
	input logic clk,
	input logic arst_n,
	input logic start,
	input bch_pkg::gf_t s1,
	input bch_pkg::gf_t s3,
	bch_err_if.source eo
);

	bch_chien_if ch_bus ();

	bch_pkg::err_count_t err_count_q;
	bch_pkg::err_count_t flip_class;
	bch_pkg::err_count_t flip_cnt;
	bch_pkg::err_count_t flips_before;
	logic err_hit;

	// Error class from a syndrome pair.
	// One error gives S3 equal to S1 cubed, and S1 of zero with S3 nonzero
	// cannot come from two errors or fewer.
	function automatic bch_pkg::err_count_t classify(input bch_pkg::gf_t a,
			input bch_pkg::gf_t b);
		if (a == '0) begin
			return (b == '0) ? 2'd0 : 2'd3;
		end
		return (b == bch_pkg::gf_cube(a)) ? 2'd1 : 2'd2;
	endfunction

	bch_chien chien_i (
		.clk(clk),
		.arst_n(arst_n),
		.start(start),
		.s1(s1),
		.s3(s3),
		.ch(ch_bus.source)
	);

	assign flip_class = classify(ch_bus.ch1, ch_bus.ch3);

	// Flips already found in this word. The count restarts at the first position.
	assign flips_before = ch_bus.first ? '0 : flip_cnt;

	// No more bits are flipped than the class says the word has.
	assign err_hit = ch_bus.valid && (flip_class < err_count_q) &&
		(flips_before < err_count_q);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			err_count_q <= '0;
			flip_cnt <= '0;
		end else begin
			if (start) begin
				err_count_q <= classify(s1, s3);
			end
			if (ch_bus.valid) begin
				flip_cnt <= flips_before + bch_pkg::err_count_t'(err_hit);
			end
		end
	end

	assign eo.valid = ch_bus.valid;
	assign eo.last = ch_bus.last;
	assign eo.err = err_hit;
	assign eo.err_count = err_count_q;

endmodule

// File: bch_pkg.sv
package bch_pkg;

	// Field width. The decoder works over GF(2^5).
	localparam int m = 5;

	// Number of correctable errors. The error decision only holds for two.
	localparam int t = 2;

	// Code length and number of data bits of the (31,21) code.
	localparam int n = 31;
	localparam int k = 21;

	// A single field element, one bit per power of alpha in the polynomial basis.
	typedef logic [m-1:0] gf_t;

	// A received codeword. Bit i is the coefficient of x^i.
	typedef logic [n-1:0] word_t;

	// The data part of a codeword, bits 30 down to 10.
	typedef logic [k-1:0] data_t;

	// Error class. Values 0 to 2 count errors, 3 flags an uncorrectable word.
	typedef logic [$clog2(t+2)-1:0] err_count_t;

	// Position index into a codeword.
	typedef logic [m-1:0] pos_t;

	// Lowest and highest codeword positions that hold data.
	localparam pos_t first_data_pos = 5'd10;
	localparam pos_t last_data_pos = pos_t'(first_data_pos + k - 1);

	// Field polynomial x^5 + x^2 + 1.
	localparam logic [m:0] prim_poly = 6'b100101;

	// The primitive element and its cube.
	localparam gf_t alpha = 5'b00010;
	localparam gf_t alpha3 = 5'b01000;

	// Start values of the search stepping registers, alpha^10 and alpha^30.
	// The second one equals alpha^-1 because alpha^31 is one.
	localparam gf_t alpha_first = 5'b10001;
	localparam gf_t alpha3_first = 5'b10010;

	// Field multiply by shift and add.
	// The partial product is reduced by the field polynomial on every shift.
	function automatic gf_t gf_mul(input gf_t a, input gf_t b);
		gf_t acc;
		gf_t sh;
		acc = '0;
		sh = a;
		for (int i = 0; i < m; i++) begin
			if (b[i]) begin
				acc = acc ^ sh;
			end
			// Multiply the running term by alpha.
			if (sh[m-1]) begin
				sh = {sh[m-2:0], 1'b0} ^ prim_poly[m-1:0];
			end else begin
				sh = {sh[m-2:0], 1'b0};
			end
		end
		return acc;
	endfunction

	// Cube of a field element.
	// A single error at position i gives S3 equal to the cube of S1.
	function automatic gf_t gf_cube(input gf_t a);
		gf_t sq;
		sq = gf_mul(a, a);
		return gf_mul(sq, a);
	endfunction

endpackage

// File: bch_synd_if.sv
`timescale 1ns/1ps

// Transfer of one codeword and its two syndromes between the syndrome stage
// and the correction stage.
// The handshake is four-phase. The source keeps word, s1 and s3 stable from
// the rise of req until ack has fallen again.
interface bch_synd_if;

	// Request from the syndrome stage.
	logic req;

	// Acknowledge from the correction stage.
	logic ack;

	// Syndromes, r(alpha) and r(alpha^3).
	bch_pkg::gf_t s1;
	bch_pkg::gf_t s3;

	// The received word itself.
	bch_pkg::word_t word;

	modport source (output req, output s1, output s3, output word, input ack);

	modport sink (input req, input s1, input s3, input word, output ack);

endinterface

// File: bch_syndrome.sv
`timescale 1ns/1ps

// Input stage of the decoder.
// It takes a word under the input handshake and evaluates the received
// polynomial at alpha and alpha^3 by Horner's rule, one bit per cycle.
module bch_syndrome (
	input logic clk,
	input logic arst_n,
	input logic in_req,
	input bch_pkg::word_t in_word,
	output logic in_ack,
	bch_synd_if.source synd
);

	typedef enum logic [1:0] {st_idle, st_ack, st_compute, st_offer} state_t;

	state_t state;
	bch_pkg::word_t word_q;
	bch_pkg::gf_t s1_acc;
	bch_pkg::gf_t s3_acc;
	bch_pkg::pos_t bit_idx;
	bch_pkg::gf_t fold_bit;
	logic fold_done;
	logic req_q;
	logic latch;
	logic fold;

	// A word is taken only while idle, so a held result is never overwritten.
	assign latch = (state == st_idle) && in_req;

	// Horner evaluation starts right after the latch and overlaps the input handshake.
	assign fold = ((state == st_ack) || (state == st_compute)) && !fold_done;

	// The received bit as a field element, either zero or one.
	assign fold_bit = {{(bch_pkg::m-1){1'b0}}, word_q[bit_idx]};

	assign in_ack = (state == st_ack);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			bit_idx <= '0;
			fold_done <= 1'b0;
			req_q <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (in_req) begin
						state <= st_ack;
						bit_idx <= bch_pkg::pos_t'(bch_pkg::n - 1);
						fold_done <= 1'b0;
					end
				end
				st_ack: begin
					// The acknowledge falls once the source has released its request.
					if (!in_req) begin
						state <= st_compute;
					end
				end
				st_compute: begin
					if (fold_done) begin
						state <= st_offer;
						req_q <= 1'b1;
					end
				end
				st_offer: begin
					// Drop req on ack, then go idle only after ack has fallen too.
					if (req_q && synd.ack) begin
						req_q <= 1'b0;
					end else if (!req_q && !synd.ack) begin
						state <= st_idle;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
			// Bit 0 is the last one folded in.
			if (fold) begin
				bit_idx <= bit_idx - 1'b1;
				if (bit_idx == '0) begin
					fold_done <= 1'b1;
				end
			end
		end
	end

	// Each step multiplies the partial sum by the evaluation point and adds the next bit.
	always_ff @(posedge clk) begin
		if (latch) begin
			word_q <= in_word;
			s1_acc <= '0;
			s3_acc <= '0;
		end else if (fold) begin
			s1_acc <= bch_pkg::gf_mul(s1_acc, bch_pkg::alpha) ^ fold_bit;
			s3_acc <= bch_pkg::gf_mul(s3_acc, bch_pkg::alpha3) ^ fold_bit;
		end
	end

	assign synd.req = req_q;
	assign synd.s1 = s1_acc;
	assign synd.s3 = s3_acc;
	assign synd.word = word_q;

endmodule

// File: compile.f
bch_pkg.sv
bch_synd_if.sv
bch_chien_if.sv
bch_err_if.sv
bch_syndrome.sv
bch_chien.sv
bch_error_dec.sv
bch_correct.sv
bch_decoder.sv
tb_clock_gen.sv
bch_decoder_tb.sv

// File: tb_clock_gen.sv
`timescale 1ns/1ps

// Free running clock for the testbench, 4 ns period.
module tb_clock_gen (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	// Half period of 2 ns.
	always #2 clk = ~clk;

endmodule
